//--- design/extract_pkg.sv
`default_nettype none

package extract_pkg;

	// ============================================================
	// Widths and sizes
	// ============================================================

	localparam int NUM_SLOTS   = 4;
	localparam int PC_W        = 32;
	localparam int LINE_W      = 512;
	localparam int INS_W       = 48;
	localparam int MIP_W       = 12;
	localparam int GROUP_DEPTH = 4;

	// Each instruction is a fixed six bytes, so slot PCs step by this amount
	localparam int INS_BYTES = INS_W / 8;

	// Group queue pointer and occupancy widths
	localparam int GQ_PTR_W = $clog2(GROUP_DEPTH);
	localparam int GQ_CNT_W = $clog2(GROUP_DEPTH + 1);

	localparam logic [PC_W-1:0] RST_PC = 32'hFFFD_0000;

	// ============================================================
	// Opcodes, held in instruction bits 6:0
	// ============================================================

	localparam logic [6:0] OP_NOP   = 7'h3F;
	localparam logic [6:0] OP_QFEXT = 7'h7D;
	localparam logic [6:0] OP_BSR   = 7'h21;
	localparam logic [6:0] OP_IRQ   = 7'h7F;

	localparam logic [INS_W-1:0] NOP_INS = {41'd0, OP_NOP};

	// ============================================================
	// Records
	// ============================================================

	typedef logic [7:0] areg_t;

	// One instruction as cut from the aligned fetch line
	typedef struct packed {
		logic [INS_W-1:0] ins;
		logic [PC_W-1:0]  pc;
	} slot_raw_t;

	// Controls that travel with a fetch line
	typedef struct packed {
		logic             nop;
		logic             branch_miss;
		logic [PC_W-1:0]  miss_pc;
		logic             hirq;
		logic [2:0]       irq_level;
		logic [7:0]       vect;
		logic             mipv;
		logic [MIP_W-1:0] mip;
	} fetch_ctrl_t;

	// A slot after the instruction mux and register decode
	typedef struct packed {
		logic [PC_W-1:0]  pc;
		logic [MIP_W-1:0] mcip;
		logic [INS_W-1:0] ins;
		areg_t            rt;
		areg_t            ra;
		areg_t            rb;
		areg_t            rc;
	} ex_ins_t;

	typedef ex_ins_t [NUM_SLOTS-1:0] group_t;

endpackage

`default_nettype wire

//--- design/fetch_align.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_align (
	input  wire logic                                      clk,
	input  wire logic                                      rst_i,
	input  wire logic                                      en_i,
	input  wire logic                                      stall_i,
	input  wire logic [extract_pkg::PC_W-1:0]              pc_i,
	input  wire logic [extract_pkg::LINE_W-1:0]            line_i,
	input  wire extract_pkg::fetch_ctrl_t                  ctrl_i,
	output extract_pkg::slot_raw_t [extract_pkg::NUM_SLOTS-1:0] slots_o,
	output extract_pkg::fetch_ctrl_t                       ctrl_o,
	output logic                                           fetch_valid_o
);

	logic                               accept;
	logic [extract_pkg::LINE_W-1:0]     line_q;
	logic [extract_pkg::PC_W-1:0]       pc_q;
	extract_pkg::fetch_ctrl_t           ctrl_q;
	logic [8:0]                         shift_amt;
	logic [extract_pkg::LINE_W-1:0]     line_aligned;

	// A line is taken only while the queue has room for it
	assign accept = en_i && !stall_i;

	// ============================================================
	// Capture registers
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst_i) begin
			fetch_valid_o <= 1'b0;
			ctrl_q <= '0;
		end else begin
			// One cycle of valid per accepted line
			fetch_valid_o <= accept;
			if (accept) begin
				ctrl_q <= ctrl_i;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			line_q <= line_i;
			pc_q <= pc_i;
		end
	end

	assign ctrl_o = ctrl_q;

	// ============================================================
	// Parcel alignment and slot cut
	// ============================================================

	// The start PC selects a 16-bit parcel within the 64-byte line
	assign shift_amt = {pc_q[5:1], 4'd0};
	assign line_aligned = line_q >> shift_amt;

	always_comb begin
		for (int i = 0; i < extract_pkg::NUM_SLOTS; i++) begin
			slots_o[i].ins = line_aligned[i*extract_pkg::INS_W +: extract_pkg::INS_W];
			slots_o[i].pc = pc_q + extract_pkg::PC_W'(i * extract_pkg::INS_BYTES);
		end
	end

endmodule

`default_nettype wire

//--- design/ins_slot_mux.sv
`timescale 1ns/10ps
`default_nettype none

module ins_slot_mux #(
	parameter int SLOT_INDEX = 0
) (
	input  wire extract_pkg::slot_raw_t         raw_i,
	input  wire extract_pkg::slot_raw_t         raw0_i,
	input  wire extract_pkg::fetch_ctrl_t       ctrl_i,
	input  wire logic [extract_pkg::INS_W-1:0]  mc_ins_i,
	output extract_pkg::ex_ins_t                ins_o
);

	logic                              kill;
	logic                              irq_take;
	logic                              qfext;
	logic [extract_pkg::INS_W-1:0]     irq_ins;
	logic [extract_pkg::INS_W-1:0]     sel_ins;
	logic [extract_pkg::PC_W-1:0]      sel_pc;
	logic [extract_pkg::MIP_W-1:0]     sel_mcip;

	// Slots that fall before a branch-miss target must not execute
	assign kill = ctrl_i.nop || (ctrl_i.branch_miss && (ctrl_i.miss_pc > raw_i.pc));

	// An interrupt is held off while a microcode sequence is running
	assign irq_take = ctrl_i.hirq && (ctrl_i.irq_level != 3'd0) && !ctrl_i.mipv;

	always_comb begin
		irq_ins = '0;
		irq_ins[6:0] = extract_pkg::OP_IRQ;
		irq_ins[14:7] = ctrl_i.vect;
		irq_ins[17:15] = ctrl_i.irq_level;
	end

	// ============================================================
	// Instruction source selection
	// ============================================================

	always_comb begin
		if (kill) begin
			sel_ins = extract_pkg::NOP_INS;
			sel_pc = extract_pkg::RST_PC;
			sel_mcip = '0;
		end else if (irq_take) begin
			// The interrupt takes the place of slot 0 and the rest of the group is dropped
			if (SLOT_INDEX == 0) begin
				sel_ins = irq_ins;
				sel_pc = raw0_i.pc;
				sel_mcip = '0;
			end else begin
				sel_ins = extract_pkg::NOP_INS;
				sel_pc = extract_pkg::RST_PC;
				sel_mcip = '0;
			end
		end else if (ctrl_i.mipv) begin
			// Microcode words come in groups of four, so the slot index fills the low bits
			sel_ins = mc_ins_i;
			sel_pc = raw_i.pc;
			sel_mcip = ctrl_i.mip | extract_pkg::MIP_W'(SLOT_INDEX);
		end else begin
			sel_ins = raw_i.ins;
			sel_pc = raw_i.pc;
			sel_mcip = '0;
		end
	end

	// ============================================================
	// Register field decode
	// ============================================================

	assign qfext = (sel_ins[6:0] == extract_pkg::OP_QFEXT);

	always_comb begin
		ins_o.pc = sel_pc;
		ins_o.mcip = sel_mcip;
		ins_o.ins = sel_ins;
		if (qfext) begin
			// The extension opcode carries three more bits for each register number
			ins_o.rt = {sel_ins[38:36], sel_ins[11:7]};
			ins_o.ra = {sel_ins[41:39], sel_ins[16:12]};
			ins_o.rb = {sel_ins[44:42], sel_ins[21:17]};
			ins_o.rc = {sel_ins[47:45], sel_ins[26:22]};
		end else begin
			ins_o.rt = {3'd0, sel_ins[11:7]};
			ins_o.ra = {3'd0, sel_ins[16:12]};
			ins_o.rb = {3'd0, sel_ins[21:17]};
			ins_o.rc = {3'd0, sel_ins[26:22]};
		end
	end

endmodule

`default_nettype wire

//--- design/bsr_scan.sv
`timescale 1ns/10ps
`default_nettype none

module bsr_scan (
	input  wire logic                          clk,
	input  wire logic                          rst_i,
	input  wire logic                          load_i,
	input  wire extract_pkg::group_t           group_i,
	output logic                               do_bsr_o,
	output logic [extract_pkg::PC_W-1:0]       bsr_tgt_o
);

	logic                              found;
	logic [extract_pkg::PC_W-1:0]      tgt;

	// Scan from the top so the lowest BSR slot is the one left standing
	always_comb begin
		found = 1'b0;
		tgt = extract_pkg::RST_PC;
		for (int i = extract_pkg::NUM_SLOTS - 1; i >= 0; i--) begin
			if (group_i[i].ins[6:0] == extract_pkg::OP_BSR) begin
				found = 1'b1;
				// Displacement is bits 47:11, sign-extended then cut to the PC width
				tgt = group_i[i].pc +
					extract_pkg::PC_W'($signed(group_i[i].ins[extract_pkg::INS_W-1:11]));
			end
		end
	end

	// The result stays put until the next group is pushed
	always_ff @(posedge clk) begin
		if (rst_i) begin
			do_bsr_o <= 1'b0;
			bsr_tgt_o <= extract_pkg::RST_PC;
		end else if (load_i) begin
			do_bsr_o <= found;
			bsr_tgt_o <= tgt;
		end
	end

endmodule

`default_nettype wire

//--- design/group_queue.sv
`timescale 1ns/10ps
`default_nettype none

module group_queue (
	input  wire logic                  clk,
	input  wire logic                  rst_i,
	input  wire logic                  push_i,
	input  wire extract_pkg::group_t   group_i,
	input  wire logic                  get_i,
	input  wire logic                  stomp_i,
	output extract_pkg::group_t        group_o,
	output logic                       valid_o,
	output logic                       stall_o
);

	extract_pkg::group_t                   mem [extract_pkg::GROUP_DEPTH];
	logic [extract_pkg::GQ_PTR_W-1:0]      wr_ptr;
	logic [extract_pkg::GQ_PTR_W-1:0]      rd_ptr;
	logic [extract_pkg::GQ_CNT_W-1:0]      count;
	logic                                  do_push;
	logic                                  do_pop;

	function automatic logic [extract_pkg::GQ_PTR_W-1:0] ptr_next(
		input logic [extract_pkg::GQ_PTR_W-1:0] ptr
	);
		if (ptr == extract_pkg::GQ_PTR_W'(extract_pkg::GROUP_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// A stomp also throws away the group that is still coming out of the aligner
	assign do_push = push_i && !stomp_i;
	assign do_pop = get_i && !stomp_i && (count != '0);

	// Reserve a place for the group in flight so it always finds room
	assign stall_o = (count + extract_pkg::GQ_CNT_W'(push_i)) >=
		extract_pkg::GQ_CNT_W'(extract_pkg::GROUP_DEPTH);

	// ============================================================
	// Storage and output registers
	// ============================================================

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= group_i;
		end
	end

	always_ff @(posedge clk) begin
		if (do_pop) begin
			group_o <= mem[rd_ptr];
		end
	end

	// ============================================================
	// Pointers, count and valid
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst_i || stomp_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			valid_o <= 1'b0;
		end else begin
			if (do_push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// A get on an empty queue shows the consumer there is nothing new
			if (get_i) begin
				valid_o <= (count != '0);
			end
		end
	end

	// Stall must keep the aligner from overrunning the queue
	a_no_push_full: assert property (@(posedge clk) disable iff (rst_i)
		push_i |-> (count < extract_pkg::GQ_CNT_W'(extract_pkg::GROUP_DEPTH)));

	a_stomp_clears: assert property (@(posedge clk) disable iff (rst_i)
		stomp_i |=> !valid_o);

endmodule

`default_nettype wire

//--- design/ins_extract.sv
`timescale 1ns/10ps
`default_nettype none

module ins_extract (
	input  wire logic                                                   clk,
	input  wire logic                                                   rst_i,
	input  wire logic                                                   en_i,
	input  wire logic [extract_pkg::PC_W-1:0]                           pc_i,
	input  wire logic [extract_pkg::LINE_W-1:0]                         line_i,
	input  wire extract_pkg::fetch_ctrl_t                               ctrl_i,
	input  wire logic [extract_pkg::NUM_SLOTS-1:0][extract_pkg::INS_W-1:0] mc_ins_i,
	input  wire logic                                                   get_i,
	input  wire logic                                                   stomp_i,
	output extract_pkg::group_t                                         group_o,
	output logic                                                        valid_o,
	output logic                                                        stall_o,
	output logic                                                        do_bsr_o,
	output logic [extract_pkg::PC_W-1:0]                                bsr_tgt_o
);

	extract_pkg::slot_raw_t [extract_pkg::NUM_SLOTS-1:0] slots;
	extract_pkg::fetch_ctrl_t                            ctrl;
	logic                                                fetch_valid;
	wire extract_pkg::group_t                            dec_group;

	fetch_align u_fetch_align (
		.clk           (clk),
		.rst_i         (rst_i),
		.en_i          (en_i),
		.stall_i       (stall_o),
		.pc_i          (pc_i),
		.line_i        (line_i),
		.ctrl_i        (ctrl_i),
		.slots_o       (slots),
		.ctrl_o        (ctrl),
		.fetch_valid_o (fetch_valid)
	);

	// Microcode words are read in the cycle after the line, from the registered mip
	for (genvar gi = 0; gi < extract_pkg::NUM_SLOTS; gi++) begin : g_slot
		ins_slot_mux #(
			.SLOT_INDEX (gi)
		) u_slot_mux (
			.raw_i    (slots[gi]),
			.raw0_i   (slots[0]),
			.ctrl_i   (ctrl),
			.mc_ins_i (mc_ins_i[gi]),
			.ins_o    (dec_group[gi])
		);
	end

	bsr_scan u_bsr_scan (
		.clk       (clk),
		.rst_i     (rst_i),
		.load_i    (fetch_valid),
		.group_i   (dec_group),
		.do_bsr_o  (do_bsr_o),
		.bsr_tgt_o (bsr_tgt_o)
	);

	group_queue u_group_queue (
		.clk     (clk),
		.rst_i   (rst_i),
		.push_i  (fetch_valid),
		.group_i (dec_group),
		.get_i   (get_i),
		.stomp_i (stomp_i),
		.group_o (group_o),
		.valid_o (valid_o),
		.stall_o (stall_o)
	);

endmodule

`default_nettype wire

//--- test/tb_ins_extract.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ins_extract;

	localparam int WAIT_LIMIT = 200;
	localparam int K_PLAIN = 0;
	localparam int K_NOP = 1;
	localparam int K_MISS = 2;
	localparam int K_MCODE = 3;
	localparam int K_IRQ = 4;
	localparam int K_IRQ_MC = 5;

	logic                                          clk;
	logic                                          rst_i;
	logic                                          en_i;
	logic [extract_pkg::PC_W-1:0]                  pc_i;
	logic [extract_pkg::LINE_W-1:0]                line_i;
	extract_pkg::fetch_ctrl_t                      ctrl_i;
	logic [extract_pkg::NUM_SLOTS-1:0][extract_pkg::INS_W-1:0] mc_ins_i;
	logic                                          get_i;
	logic                                          stomp_i;
	extract_pkg::group_t                           group_o;
	logic                                          valid_o;
	logic                                          stall_o;
	logic                                          do_bsr_o;
	logic [extract_pkg::PC_W-1:0]                  bsr_tgt_o;

	// Expected groups in the order the DUT must hand them out
	extract_pkg::group_t model_q[$];
	extract_pkg::group_t exp_group;
	int                  get_mode;
	logic                get_seen;
	logic                stomp_seen;
	logic                rst_seen;

	ins_extract i_ins_extract (
		.clk       (clk),
		.rst_i     (rst_i),
		.en_i      (en_i),
		.pc_i      (pc_i),
		.line_i    (line_i),
		.ctrl_i    (ctrl_i),
		.mc_ins_i  (mc_ins_i),
		.get_i     (get_i),
		.stomp_i   (stomp_i),
		.group_o   (group_o),
		.valid_o   (valid_o),
		.stall_o   (stall_o),
		.do_bsr_o  (do_bsr_o),
		.bsr_tgt_o (bsr_tgt_o)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// ============================================================
	// Reference model
	// ============================================================

	function automatic extract_pkg::ex_ins_t make_record(input logic [31:0] pc,
		input logic [11:0] mcip, input logic [47:0] ins);
		extract_pkg::ex_ins_t rec;
		logic ext;
		ext = (ins[6:0] == extract_pkg::OP_QFEXT);
		rec.pc = pc;
		rec.mcip = mcip;
		rec.ins = ins;
		rec.rt = {(ext ? ins[38:36] : 3'b000), ins[11:7]};
		rec.ra = {(ext ? ins[41:39] : 3'b000), ins[16:12]};
		rec.rb = {(ext ? ins[44:42] : 3'b000), ins[21:17]};
		rec.rc = {(ext ? ins[47:45] : 3'b000), ins[26:22]};
		return rec;
	endfunction

	function automatic extract_pkg::group_t expected_group(input logic [31:0] pc,
		input logic [511:0] line, input extract_pkg::fetch_ctrl_t ctrl,
		input logic [3:0][47:0] mc);
		extract_pkg::group_t g;
		extract_pkg::ex_ins_t nop_rec;
		logic [511:0] shifted;
		logic [31:0] spc;
		logic irq;
		nop_rec = make_record(extract_pkg::RST_PC, 12'd0, extract_pkg::NOP_INS);
		shifted = line >> (16 * int'(pc[5:1]));
		irq = ctrl.hirq && (ctrl.irq_level != 3'd0) && !ctrl.mipv;
		for (int i = 0; i < 4; i++) begin
			spc = pc + 32'(6 * i);
			if (ctrl.nop || (ctrl.branch_miss && (ctrl.miss_pc > spc))) begin
				g[i] = nop_rec;
			end else if (irq) begin
				g[i] = (i == 0) ? make_record(spc, 12'd0,
					{30'd0, ctrl.irq_level, ctrl.vect, extract_pkg::OP_IRQ}) : nop_rec;
			end else if (ctrl.mipv) begin
				g[i] = make_record(spc, ctrl.mip | 12'(i), mc[i]);
			end else begin
				g[i] = make_record(spc, 12'd0, shifted[48*i +: 48]);
			end
		end
		return g;
	endfunction

	// Flag in bit 32, target below it
	function automatic logic [32:0] expected_bsr(input extract_pkg::group_t g);
		logic [63:0] disp;
		for (int i = 0; i < 4; i++) begin
			if (g[i].ins[6:0] == extract_pkg::OP_BSR) begin
				disp = {{27{g[i].ins[47]}}, g[i].ins[47:11]};
				return {1'b1, g[i].pc + disp[31:0]};
			end
		end
		return {1'b0, extract_pkg::RST_PC};
	endfunction

	// ============================================================
	// Stimulus helpers
	// ============================================================

	task automatic random_fetch(output logic [31:0] pc, output logic [511:0] line,
		output logic [3:0][47:0] mc);
		int off;
		pc = $urandom();
		pc[5:0] = 6'($urandom_range(40, 0));
		for (int w = 0; w < 16; w++) line[32*w +: 32] = $urandom();
		for (int i = 0; i < 4; i++) begin
			off = 16 * int'(pc[5:1]) + 48 * i;
			case ($urandom_range(3, 0))
				0: line[off +: 7] = extract_pkg::OP_QFEXT;
				1: line[off +: 7] = extract_pkg::OP_BSR;
				2: line[off +: 7] = extract_pkg::OP_NOP;
				default: ;
			endcase
			mc[i] = {16'($urandom()), 32'($urandom())};
			if ($urandom_range(1, 0) == 1) mc[i][6:0] = extract_pkg::OP_QFEXT;
		end
	endtask

	function automatic extract_pkg::fetch_ctrl_t make_ctrl(input int kind,
		input logic [31:0] pc);
		extract_pkg::fetch_ctrl_t c;
		c = '0;
		if (kind == K_NOP) c.nop = 1'b1;
		if (kind == K_MISS) begin
			c.branch_miss = 1'b1;
			c.miss_pc = pc + 32'($urandom_range(24, 0));
		end
		if (kind == K_MCODE || kind == K_IRQ_MC) begin
			c.mipv = 1'b1;
			c.mip = 12'($urandom());
		end
		if (kind == K_IRQ || kind == K_IRQ_MC) begin
			c.hirq = 1'b1;
			c.irq_level = 3'($urandom_range(7, 1));
			c.vect = 8'($urandom());
		end
		return c;
	endfunction

	task automatic compare_values(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			$display("sim failed");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("sim failed");
		$fatal(1, "timeout: %s", what);
	endtask

	// Mode 0 withholds get, 1 gets at random, 2 gets every cycle
	task automatic next_cycle();
		@(posedge clk);
		#2;
		get_i = (get_mode == 2) || (get_mode == 1 && $urandom_range(1, 0) == 1);
		stomp_i = 1'b0;
	endtask

	task automatic send_line(input int kind);
		logic [31:0] pc;
		logic [511:0] line;
		logic [3:0][47:0] mc;
		extract_pkg::fetch_ctrl_t ctrl;
		extract_pkg::group_t exp;
		logic [32:0] bsr;
		int waited;
		random_fetch(pc, line, mc);
		ctrl = make_ctrl(kind, pc);
		exp = expected_group(pc, line, ctrl, mc);
		bsr = expected_bsr(exp);
		waited = 0;
		while (stall_o) begin
			next_cycle();
			waited++;
			if (waited > WAIT_LIMIT) report_timeout("stall_o stayed high, no line could be sent");
		end
		en_i = 1'b1;
		pc_i = pc;
		line_i = line;
		ctrl_i = ctrl;
		mc_ins_i = mc;
		next_cycle();
		// The microcode words are still read during the cycle after acceptance
		en_i = 1'b0;
		next_cycle();
		model_q.push_back(exp);
		compare_values("do_bsr_o", 128'(do_bsr_o), 128'(bsr[32]));
		compare_values("bsr_tgt_o", 128'(bsr_tgt_o), 128'(bsr[31:0]));
	endtask

	task automatic run_lines(input int n, input int kind);
		for (int i = 0; i < n; i++) send_line(kind);
	endtask

	task automatic drain_queue();
		int waited;
		waited = 0;
		get_mode = 2;
		while (model_q.size() > 0) begin
			next_cycle();
			waited++;
			if (waited > WAIT_LIMIT) report_timeout("the queue did not drain");
		end
		get_mode = 0;
		next_cycle();
	endtask

	// ============================================================
	// Output compare
	// ============================================================

	always @(posedge clk) begin
		get_seen = get_i;
		stomp_seen = stomp_i;
		rst_seen = rst_i;
		#1;
		if (!rst_seen) begin
			if (stomp_seen) begin
				model_q.delete();
				compare_values("valid_o", 128'(valid_o), 128'(0));
			end else if (get_seen && model_q.size() > 0) begin
				exp_group = model_q.pop_front();
				compare_values("valid_o", 128'(valid_o), 128'(1));
				for (int i = 0; i < 4; i++) begin
					compare_values($sformatf("group_o[%0d]", i), 128'(group_o[i]),
						128'(exp_group[i]));
				end
			end else if (get_seen) begin
				compare_values("valid_o", 128'(valid_o), 128'(0));
			end
		end
	end

	initial begin
		int unsigned seed_ret;
		seed_ret = $urandom(32'h4402_afc7);
		rst_i = 1'b1;
		en_i = 1'b0;
		pc_i = '0;
		line_i = '0;
		ctrl_i = '0;
		mc_ins_i = '0;
		get_i = 1'b0;
		stomp_i = 1'b0;
		get_mode = 0;
		repeat (16) @(posedge clk);
		#2;
		compare_values("valid_o", 128'(valid_o), 128'(0));
		compare_values("stall_o", 128'(stall_o), 128'(0));
		compare_values("do_bsr_o", 128'(do_bsr_o), 128'(0));
		compare_values("bsr_tgt_o", 128'(bsr_tgt_o), 128'(extract_pkg::RST_PC));
		rst_i = 1'b0;

		// Plain lines with mixed opcodes, BSRs and random gets
		get_mode = 1;
		run_lines(24, K_PLAIN);
		run_lines(3, K_NOP);
		run_lines(8, K_MISS);
		run_lines(6, K_MCODE);
		run_lines(5, K_IRQ);
		run_lines(4, K_IRQ_MC);
		drain_queue();

		// With no gets the queue fills and stall_o holds the aligner
		run_lines(extract_pkg::GROUP_DEPTH, K_PLAIN);
		compare_values("stall_o", 128'(stall_o), 128'(1));
		drain_queue();
		compare_values("stall_o", 128'(stall_o), 128'(0));

		// Stomp with a get in the same cycle, then only new lines come out
		run_lines(2, K_PLAIN);
		get_mode = 2;
		next_cycle();
		get_mode = 0;
		next_cycle();
		@(posedge clk);
		#2;
		stomp_i = 1'b1;
		get_i = 1'b1;
		next_cycle();
		run_lines(1, K_PLAIN);
		drain_queue();

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
design/extract_pkg.sv
design/fetch_align.sv
design/ins_slot_mux.sv
design/bsr_scan.sv
design/group_queue.sv
design/ins_extract.sv
test/tb_ins_extract.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_ins_extract
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the Verilator simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
